// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps
TOP = tb_arcade_input
FILELIST = filelist.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: arcade_defs.svh
//======================================
// Arcade input front end constants
// Download indices, DIP bank size, bus
// widths and the loader's game codes
//======================================
`ifndef ARCADE_DEFS_SVH
`define ARCADE_DEFS_SVH

// Download port indices as sent by the loader
// ROM image, also the reset source during transfer
`define DL_INDEX_ROM 8'd0
// Single game-select byte
`define DL_INDEX_GAME 8'd1
// DIP switch block
`define DL_INDEX_DIP 8'd254

// Download bus widths
`define DL_INDEX_BITS 8
`define DL_ADDR_BITS 25
`define DL_DATA_BITS 8

// DIP bank, eight switch bytes
`define DIP_COUNT 8
`define DIP_ADDR_BITS 3

// Generic byte and joystick word widths
`define BYTE_BITS 8
`define JOY_BITS 16

// Game codes, one spare code above them marks no game
`define GAME_CODE_BITS 3
`define GAME_BWIDOW 3'd0
`define GAME_GRAVITAR 3'd1
`define GAME_LUNARBAT 3'd2
`define GAME_SPACDUEL 3'd3
`define GAME_NONE 3'd4

`endif

// File: arcade_input_top.sv
//======================================
// Arcade input front end top level
// Download decode, joystick source
// select and cabinet byte map
//======================================
`include "arcade_defs.svh"

module arcade_input_top import arcade_pkg::*; (
	input logic clk_12,
	input logic reset,
	input dl_write_t dl,
	input logic download,
	input logic status_reset,
	input logic user_reset,
	input joy_mode_t mode,
	input ctrl_word_t usb_0,
	input ctrl_word_t usb_1,
	input logic [`JOY_BITS-1:0] db9_1,
	input logic [`JOY_BITS-1:0] db9_2,
	input logic [`JOY_BITS-1:0] db15_1,
	input logic [`JOY_BITS-1:0] db15_2,
	output cab_inputs_t cab,
	output logic core_reset,
	output logic osd_request
);

	// Decoded game and switch bank
	game_t game;
	dip_bank_t dips;

	// Player words after source select
	ctrl_word_t player_0;
	ctrl_word_t player_1;

	// Loader writes and core reset
	download_decoder u_download_decoder (
		.clk_12(clk_12),
		.reset(reset),
		.dl(dl),
		.download(download),
		.status_reset(status_reset),
		.user_reset(user_reset),
		.game(game),
		.dips(dips),
		.core_reset(core_reset)
	);

	// USB or user-port joysticks, no clock
	joystick_select u_joystick_select (
		.mode(mode),
		.usb_0(usb_0),
		.usb_1(usb_1),
		.db9_1(db9_1),
		.db9_2(db9_2),
		.db15_1(db15_1),
		.db15_2(db15_2),
		.player_0(player_0),
		.player_1(player_1),
		.osd_request(osd_request)
	);

	// Registered cabinet bytes
	cabinet_input_map u_cabinet_input_map (
		.clk_12(clk_12),
		.reset(reset),
		.game(game),
		.dips(dips),
		.player_0(player_0),
		.player_1(player_1),
		.cab(cab)
	);

endmodule

// File: arcade_pkg.sv
//======================================
// Arcade input types
// Download strobe, joystick mode, player
// control word, DIP bank and cabinet bytes
//======================================
`include "arcade_defs.svh"

package arcade_pkg;

	// Selected game, GAME_NONE for any unknown loader code
	typedef enum logic [`GAME_CODE_BITS-1:0] {
		BWIDOW = `GAME_BWIDOW,
		GRAVITAR = `GAME_GRAVITAR,
		LUNARBAT = `GAME_LUNARBAT,
		SPACDUEL = `GAME_SPACDUEL,
		GAME_NONE = `GAME_NONE
	} game_t;

	// One download strobe from the loader
	// wr lasts one cycle, no back-pressure
	typedef struct packed {
		logic wr;
		logic [`DL_INDEX_BITS-1:0] index;
		logic [`DL_ADDR_BITS-1:0] addr;
		logic [`DL_DATA_BITS-1:0] data;
	} dl_write_t;

	// User-port joystick setting from the OSD
	typedef struct packed {
		logic db9md_en;
		logic db15_en;
		logic two_players;
	} joy_mode_t;

	// Common player word, USB joystick bit order
	// Declared MSB first, so right sits at bit 0
	typedef struct packed {
		logic [3:0] spare;
		logic pause;
		logic coin;
		logic start2;
		logic start1;
		logic fire_up;
		logic fire_down;
		logic fire_left;
		logic fire_right;
		logic up;
		logic down;
		logic left;
		logic right;
	} ctrl_word_t;

	// DIP switch bytes, index 0 in the low byte
	typedef logic [`DIP_COUNT-1:0][`BYTE_BITS-1:0] dip_bank_t;

	// Five active-low cabinet input bytes
	typedef struct packed {
		logic [`BYTE_BITS-1:0] in0;
		logic [`BYTE_BITS-1:0] in1;
		logic [`BYTE_BITS-1:0] in2;
		logic [`BYTE_BITS-1:0] in3;
		logic [`BYTE_BITS-1:0] in4;
	} cab_inputs_t;

endpackage

// File: cabinet_input_map.sv
//======================================
// Cabinet input map
// Builds named controls from both players
// and registers the five active-low input
// bytes of the selected game
//======================================
`include "arcade_defs.svh"

module cabinet_input_map import arcade_pkg::*; (
	input logic clk_12,
	input logic reset,
	input game_t game,
	input dip_bank_t dips,
	input ctrl_word_t player_0,
	input ctrl_word_t player_1,
	output cab_inputs_t cab
);

	// Named controls in the common word layout
	ctrl_word_t ctl;

	// Next cabinet bytes
	cab_inputs_t cab_d;

	// Coin and DIP bits shared by the first three games
	logic [`BYTE_BITS-1:0] in0_common;

	// ======================================
	// Named controls
	// ======================================
	always_comb begin
		ctl = '0;
		// Movement only from the first player
		ctl.up = player_0.up;
		ctl.down = player_0.down;
		ctl.left = player_0.left;
		ctl.right = player_0.right;
		// Second stick doubles as the fire stick for twin-stick play
		ctl.fire_up = player_0.fire_up | player_1.up;
		ctl.fire_down = player_0.fire_down | player_1.down;
		ctl.fire_left = player_0.fire_left | player_1.left;
		ctl.fire_right = player_0.fire_right | player_1.right;
		// Start and coin from either player
		ctl.start1 = player_0.start1 | player_1.start1;
		ctl.start2 = player_0.start2 | player_1.start2;
		ctl.coin = player_0.coin | player_1.coin;
	end

	// Bit 6 high, DIP byte 2 low bits reversed, coin at bit 1
	assign in0_common = ~{1'b0, 1'b1, dips[2][0], dips[2][1], 2'b00, ctl.coin, 1'b0};

	// ======================================
	// Per-game byte layout
	// ======================================
	always_comb begin
		// Default covers Space Duel and no game, only the DIPs reach the core
		cab_d.in0 = 8'hff;
		cab_d.in1 = dips[0];
		cab_d.in2 = dips[1];
		cab_d.in3 = 8'hff;
		cab_d.in4 = 8'hff;
		case (game)
			BWIDOW: begin
				cab_d.in0 = in0_common;
				cab_d.in3 = ~{4'b0000, ctl.up, ctl.down, ctl.left, ctl.right};
				cab_d.in4 = ~{1'b0, ctl.start2, ctl.start1, 1'b0,
					ctl.fire_up, ctl.fire_down, ctl.fire_left, ctl.fire_right};
			end
			GRAVITAR: begin
				cab_d.in0 = in0_common;
				// Rotate, thrust and shield share the movement byte
				cab_d.in3 = ~{3'b000, ctl.fire_left, ctl.left, ctl.right,
					ctl.fire_right, ctl.fire_down};
				cab_d.in4 = ~{1'b0, ctl.start2, ctl.start1, 5'b00000};
			end
			LUNARBAT: begin
				cab_d.in0 = in0_common;
				cab_d.in1 = 8'hff;
				cab_d.in2 = 8'hff;
				// Active high on this board
				cab_d.in3 = {1'b0, ctl.start2, ctl.start1, ctl.fire_left,
					ctl.fire_down, ctl.fire_right, ctl.right, ctl.left};
			end
			default: begin
				cab_d.in0 = 8'hff;
			end
		endcase
	end

	// One cycle from any input to the bytes, idle means all released
	always_ff @(posedge clk_12) begin
		if (reset) begin
			cab <= '1;
		end else begin
			cab <= cab_d;
		end
	end

endmodule

// File: download_decoder.sv
//======================================
// Download decoder
// Takes loader writes into the game code
// and the DIP bank, and builds the
// registered core reset from its sources
//======================================
`include "arcade_defs.svh"

module download_decoder import arcade_pkg::*; (
	input logic clk_12,
	input logic reset,
	input dl_write_t dl,
	input logic download,
	input logic status_reset,
	input logic user_reset,
	output game_t game,
	output dip_bank_t dips,
	output logic core_reset
);

	// Last strobed index, raw game byte and switch bank
	logic [`DL_INDEX_BITS-1:0] last_index;
	logic [`DL_DATA_BITS-1:0] game_code;
	dip_bank_t dip_q;

	// Index seen by the reset logic, a strobe this cycle wins
	logic rom_selected;

	// DIP writes only inside the first eight addresses
	logic dip_addr_ok;

	assign dip_addr_ok = (dl.addr[`DL_ADDR_BITS-1:`DIP_ADDR_BITS] == '0);
	assign rom_selected = dl.wr ? (dl.index == `DL_INDEX_ROM) : (last_index == `DL_INDEX_ROM);

	// ======================================
	// Download write capture
	// ======================================
	always_ff @(posedge clk_12) begin
		if (reset) begin
			// Boot state matches the loader, which starts with the ROM
			last_index <= `DL_INDEX_ROM;
			game_code <= `DL_DATA_BITS'(`GAME_BWIDOW);
			dip_q <= '0;
		end else if (dl.wr) begin
			last_index <= dl.index;
			if (dl.index == `DL_INDEX_GAME) begin
				game_code <= dl.data;
			end
			if (dl.index == `DL_INDEX_DIP && dip_addr_ok) begin
				dip_q[dl.addr[`DIP_ADDR_BITS-1:0]] <= dl.data;
			end
		end
	end

	assign dips = dip_q;

	// Game code decode, anything above the known set selects no game
	always_comb begin
		case (game_code)
			`DL_DATA_BITS'(`GAME_BWIDOW): game = BWIDOW;
			`DL_DATA_BITS'(`GAME_GRAVITAR): game = GRAVITAR;
			`DL_DATA_BITS'(`GAME_LUNARBAT): game = LUNARBAT;
			`DL_DATA_BITS'(`GAME_SPACDUEL): game = SPACDUEL;
			default: game = GAME_NONE;
		endcase
	end

	// ======================================
	// Core reset
	// ======================================
	// Held for the whole ROM transfer so the CPU never runs on a partial image
	always_ff @(posedge clk_12) begin
		core_reset <= reset | status_reset | user_reset | (download & rom_selected);
	end

endmodule

// File: filelist.f
+incdir+.
arcade_pkg.sv
download_decoder.sv
joystick_select.sv
cabinet_input_map.sv
arcade_input_top.sv
tb_arcade_input.sv

// File: joystick_select.sv
//======================================
// Joystick source select
// Chooses USB or user-port adapter per
// player and remaps adapter words onto
// the common control word
//======================================
`include "arcade_defs.svh"

module joystick_select import arcade_pkg::*; (
	input joy_mode_t mode,
	input ctrl_word_t usb_0,
	input ctrl_word_t usb_1,
	input logic [`JOY_BITS-1:0] db9_1,
	input logic [`JOY_BITS-1:0] db9_2,
	input logic [`JOY_BITS-1:0] db15_1,
	input logic [`JOY_BITS-1:0] db15_2,
	output ctrl_word_t player_0,
	output ctrl_word_t player_1,
	output logic osd_request
);

	// Adapter words after the DB9 or DB15 choice
	logic [`JOY_BITS-1:0] db_1;
	logic [`JOY_BITS-1:0] db_2;

	// Any user-port adapter fitted
	logic adapter_en;

	// Adapter words in control word order
	ctrl_word_t remap_1;
	ctrl_word_t remap_2;

	// ======================================
	// Adapter word remap
	// ======================================
	// Adapter layout: bits 3..0 UDLR, 4 A, 5 B, 6 C or X, 7 Y, 9 mode, 10 start
	// swap_start exchanges the two start buttons, as the second port is wired
	function automatic ctrl_word_t remap(
		input logic [`JOY_BITS-1:0] w,
		input logic swap_start
	);
		ctrl_word_t c;
		c = '0;
		// Directions pass straight through
		c.right = w[0];
		c.left = w[1];
		c.down = w[2];
		c.up = w[3];
		// Face buttons onto the four fire directions
		c.fire_right = w[5];
		c.fire_left = w[4];
		c.fire_down = w[6];
		c.fire_up = w[7];
		c.start1 = swap_start ? w[9] : w[10];
		c.start2 = swap_start ? w[10] : w[9];
		// Coin also on start plus B for pads without a spare button
		c.coin = w[11] | (w[10] & w[5]);
		c.pause = 1'b0;
		return c;
	endfunction

	// DB9 Mega Drive wins over DB15 when both are set
	always_comb begin
		if (mode.db9md_en) begin
			db_1 = db9_1;
			db_2 = db9_2;
		end else if (mode.db15_en) begin
			db_1 = db15_1;
			db_2 = db15_2;
		end else begin
			db_1 = '0;
			db_2 = '0;
		end
	end

	assign adapter_en = mode.db9md_en | mode.db15_en;
	assign remap_1 = remap(db_1, 1'b0);
	assign remap_2 = remap(db_2, 1'b1);

	// ======================================
	// Player source precedence
	// ======================================
	always_comb begin
		player_0 = adapter_en ? remap_1 : usb_0;
		// With one adapter player the first USB pad moves to player two
		if (adapter_en && mode.two_players) begin
			player_1 = remap_2;
		end else if (adapter_en) begin
			player_1 = usb_0;
		end else begin
			player_1 = usb_1;
		end
	end

	// Start plus C opens the OSD from the adapter
	assign osd_request = db_1[10] & db_1[6];

endmodule

// File: tb_arcade_input.sv
//======================================
// Arcade input front end testbench
// Directed tests of reset, DIP load, game
// select, joystick source and core reset
//======================================
`include "arcade_defs.svh"

module tb_arcade_input import arcade_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	logic clk_12 = 1'b0;
	logic reset;
	dl_write_t dl;
	logic download;
	logic status_reset;
	logic user_reset;
	joy_mode_t mode;
	ctrl_word_t usb_0;
	ctrl_word_t usb_1;
	logic [`JOY_BITS-1:0] db9_1;
	logic [`JOY_BITS-1:0] db9_2;
	logic [`JOY_BITS-1:0] db15_1;
	logic [`JOY_BITS-1:0] db15_2;
	cab_inputs_t cab;
	logic core_reset;
	logic osd_request;

	// Expected decoder state as built from the writes sent
	logic [`DL_DATA_BITS-1:0] exp_code;
	dip_bank_t exp_dips;
	int errors;
	int timeouts;
	int seed;

	arcade_input_top UUT (
		.clk_12(clk_12), .reset(reset), .dl(dl), .download(download),
		.status_reset(status_reset), .user_reset(user_reset), .mode(mode),
		.usb_0(usb_0), .usb_1(usb_1), .db9_1(db9_1), .db9_2(db9_2),
		.db15_1(db15_1), .db15_2(db15_2), .cab(cab), .core_reset(core_reset),
		.osd_request(osd_request)
	);

	// 4 ns clock
	initial begin
		forever #2 clk_12 = ~clk_12;
	end

	// ======================================
	// Reference model
	// ======================================
	function automatic game_t expected_game(input logic [7:0] code);
		case (code)
			8'd0: return BWIDOW;
			8'd1: return GRAVITAR;
			8'd2: return LUNARBAT;
			8'd3: return SPACDUEL;
			default: return GAME_NONE;
		endcase
	endfunction

	// DB9 first, then DB15, else nothing
	function automatic logic [`JOY_BITS-1:0] adapter_word(input logic second);
		if (mode.db9md_en)
			return second ? db9_2 : db9_1;
		if (mode.db15_en)
			return second ? db15_2 : db15_1;
		return '0;
	endfunction

	function automatic ctrl_word_t decode_adapter(input logic [15:0] w, input logic second);
		ctrl_word_t c;
		c = '0;
		{c.up, c.down, c.left, c.right} = w[3:0];
		c.fire_right = w[5];
		c.fire_left = w[4];
		c.fire_down = w[6];
		c.fire_up = w[7];
		// Player two has its start buttons swapped
		c.start1 = second ? w[9] : w[10];
		c.start2 = second ? w[10] : w[9];
		c.coin = w[11] | (w[10] & w[5]);
		return c;
	endfunction

	function automatic ctrl_word_t expected_player(input logic second);
		logic adapter;
		adapter = mode.db9md_en | mode.db15_en;
		if (!second)
			return adapter ? decode_adapter(adapter_word(1'b0), 1'b0) : usb_0;
		if (adapter && mode.two_players)
			return decode_adapter(adapter_word(1'b1), 1'b1);
		return adapter ? usb_0 : usb_1;
	endfunction

	function automatic cab_inputs_t expected_cab(input game_t g, input dip_bank_t d,
		input ctrl_word_t p0, input ctrl_word_t p1);
		cab_inputs_t e;
		logic fu, fd, fl, fr, s1, s2, coin;
		logic [7:0] in0_bw;
		// Second stick acts as fire stick
		fu = p0.fire_up | p1.up;
		fd = p0.fire_down | p1.down;
		fl = p0.fire_left | p1.left;
		fr = p0.fire_right | p1.right;
		s1 = p0.start1 | p1.start1;
		s2 = p0.start2 | p1.start2;
		coin = p0.coin | p1.coin;
		in0_bw = ~{1'b0, 1'b1, d[2][0], d[2][1], 2'b00, coin, 1'b0};
		e = {8'hff, d[0], d[1], 8'hff, 8'hff};
		case (g)
			BWIDOW: begin
				e.in0 = in0_bw;
				e.in3 = ~{4'b0000, p0.up, p0.down, p0.left, p0.right};
				e.in4 = ~{1'b0, s2, s1, 1'b0, fu, fd, fl, fr};
			end
			GRAVITAR: begin
				e.in0 = in0_bw;
				e.in3 = ~{3'b000, fl, p0.left, p0.right, fr, fd};
				e.in4 = ~{1'b0, s2, s1, 5'b00000};
			end
			LUNARBAT: e = {in0_bw, 8'hff, 8'hff,
				{1'b0, s2, s1, fl, fd, fr, p0.right, p0.left}, 8'hff};
			default: e = {8'hff, d[0], d[1], 8'hff, 8'hff};
		endcase
		return e;
	endfunction

	// ======================================
	// Drive and check helpers
	// ======================================
	task automatic next_cycle();
		@(negedge clk_12);
	endtask

	// One-cycle loader strobe that also updates the expected decoder state
	task automatic download_write(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		dl = {1'b1, index, addr, data};
		if (index == `DL_INDEX_GAME)
			exp_code = data;
		if (index == `DL_INDEX_DIP && addr[`DL_ADDR_BITS-1:`DIP_ADDR_BITS] == '0)
			exp_dips[addr[2:0]] = data;
		next_cycle();
		dl = '0;
	endtask

	task automatic compare_cab(input string name, input cab_inputs_t e);
		assert (cab === e) else begin
			errors++;
			$display("mismatch %s: expected %h, actual %h", name, e, cab);
		end
	endtask

	task automatic check_cab(input string name);
		compare_cab(name, expected_cab(expected_game(exp_code), exp_dips,
			expected_player(1'b0), expected_player(1'b1)));
	endtask

	task automatic check_byte(input string name, input logic [7:0] e, input logic [7:0] a);
		assert (a === e) else begin
			errors++;
			$display("mismatch %s: expected %h, actual %h", name, e, a);
		end
	endtask

	task automatic check_bit(input string name, input logic e, input logic a);
		assert (a === e) else begin
			errors++;
			$display("mismatch %s: expected %b, actual %b", name, e, a);
		end
	endtask

	task automatic wait_core_reset(input logic level, input int limit, input string name);
		int n;
		n = 0;
		while (core_reset !== level && n < limit) begin
			next_cycle();
			n++;
		end
		if (core_reset !== level) begin
			timeouts++;
			$display("Timeout in %s: core_reset did not reach %b in %0d cycles",
				name, level, limit);
		end
	endtask

	// Spare and pause bits of the USB words stay low
	task automatic random_controls();
		logic [31:0] rnd;
		rnd = $random(seed);
		usb_0 = rnd[15:0] & 16'h0fff;
		usb_1 = rnd[31:16] & 16'h0fff;
		rnd = $random(seed);
		{db9_2, db9_1} = rnd;
		rnd = $random(seed);
		{db15_2, db15_1} = rnd;
	endtask

	// ======================================
	// Directed tests
	// ======================================
	task automatic check_reset_state();
		repeat (3) next_cycle();
		compare_cab("reset_values", '1);
		reset = 1'b0;
		wait_core_reset(1'b0, 4, "reset_values");
		// Black Widow idle with zero DIPs
		compare_cab("reset_values", {8'hbf, 8'h00, 8'h00, 8'hff, 8'hff});
		check_cab("reset_values");
	endtask

	task automatic load_dips();
		logic [7:0] value;
		for (int i = 0; i < `DIP_COUNT; i++) begin
			value = 8'h5a ^ 8'(i * 37);
			download_write(`DL_INDEX_DIP, 25'(i), value);
			next_cycle();
			if (i == 0)
				check_byte("dip_loading", value, cab.in1);
			if (i == 1)
				check_byte("dip_loading", value, cab.in2);
			check_cab("dip_loading");
		end
		// DIP byte 2 low bits into in0
		for (int v = 0; v < 4; v++) begin
			download_write(`DL_INDEX_DIP, 25'd2, 8'hf0 | 8'(v));
			next_cycle();
			check_cab("dip_in0_bits");
		end
		// Writes above the bank are ignored
		download_write(`DL_INDEX_DIP, 25'h000008, 8'hc3);
		next_cycle();
		check_cab("dip_high_addr");
		download_write(`DL_INDEX_DIP, 25'h100001, 8'h3c);
		next_cycle();
		check_cab("dip_high_addr");
	endtask

	task automatic select_games();
		logic [7:0] codes [5];
		codes = '{8'd0, 8'd1, 8'd2, 8'd3, 8'd7};
		mode = '0;
		random_controls();
		for (int k = 0; k < 5; k++) begin
			download_write(`DL_INDEX_GAME, '0, codes[k]);
			next_cycle();
			check_cab("game_select");
			random_controls();
			next_cycle();
			check_cab("game_select_controls");
		end
		download_write(`DL_INDEX_GAME, '0, 8'd0);
	endtask

	task automatic switch_joystick_modes();
		joy_mode_t modes [6];
		logic [15:0] w;
		modes = '{joy_mode_t'(3'b000), joy_mode_t'(3'b100), joy_mode_t'(3'b010),
			joy_mode_t'(3'b101), joy_mode_t'(3'b011), joy_mode_t'(3'b110)};
		for (int m = 0; m < 6; m++) begin
			mode = modes[m];
			for (int r = 0; r < 6; r++) begin
				random_controls();
				next_cycle();
				check_cab("joystick_source");
				w = adapter_word(1'b0);
				check_bit("osd_request", w[10] & w[6], osd_request);
			end
		end
		// Start plus C on the DB9 pad
		mode = joy_mode_t'(3'b100);
		db9_1 = 16'h0440;
		next_cycle();
		check_bit("osd_request", 1'b1, osd_request);
		check_cab("joystick_source");
		mode = '0;
	endtask

	task automatic pulse_reset_sources();
		status_reset = 1'b1;
		next_cycle();
		check_bit("core_reset_status", 1'b1, core_reset);
		status_reset = 1'b0;
		next_cycle();
		check_bit("core_reset_status", 1'b0, core_reset);
		user_reset = 1'b1;
		next_cycle();
		check_bit("core_reset_user", 1'b1, core_reset);
		user_reset = 1'b0;
		next_cycle();
		check_bit("core_reset_user", 1'b0, core_reset);
		// ROM transfer holds the core in reset
		download = 1'b1;
		download_write(`DL_INDEX_ROM, '0, 8'h00);
		repeat (5) begin
			check_bit("core_reset_rom", 1'b1, core_reset);
			next_cycle();
		end
		download = 1'b0;
		wait_core_reset(1'b0, 4, "core_reset_rom_end");
		// Game byte transfer leaves the core running
		download_write(`DL_INDEX_GAME, '0, 8'd0);
		download = 1'b1;
		repeat (5) begin
			next_cycle();
			check_bit("core_reset_game_dl", 1'b0, core_reset);
		end
		download = 1'b0;
		next_cycle();
		check_cab("core_reset_game_dl");
	endtask

	initial begin
		seed = 32'he386;
		errors = 0;
		timeouts = 0;
		reset = 1'b1;
		dl = '0;
		download = 1'b0;
		status_reset = 1'b0;
		user_reset = 1'b0;
		mode = '0;
		usb_0 = '0;
		usb_1 = '0;
		{db9_1, db9_2, db15_1, db15_2} = '0;
		exp_code = 8'd0;
		exp_dips = '0;
		check_reset_state();
		load_dips();
		select_games();
		switch_joystick_modes();
		pulse_reset_sources();
		$display("Finished with %0d errors and %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
